/* all.f */
+incdir+.
spi_proto_pkg.sv
axil_pkg.sv
spi_xfer_if.sv
spi_pin_sync.sv
spi_slave.sv
spi_regs.sv
spi_subsys_top.sv
tb_spi_subsys.sv

/* axil_pkg.sv */
`default_nettype none

`include "spi_settings.svh"

package axil_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_t;

  // Word index taken from address bits 3:2
  typedef enum logic [1:0] {
    IDX_CTRL   = 2'(`REG_CTRL >> 2),
    IDX_TXDATA = 2'(`REG_TXDATA >> 2),
    IDX_RXDATA = 2'(`REG_RXDATA >> 2),
    IDX_STATUS = 2'(`REG_STATUS >> 2)
  } reg_idx_t;

endpackage

`default_nettype wire

/* spi_pin_sync.sv */
`default_nettype none

module spi_pin_sync (
  input  logic sendclk,
  input  logic rst_n,
  input  logic select,
  input  logic mclk,
  input  logic mosi,
  output logic sel_level,
  output logic sel_rise,
  output logic mclk_rise,
  output logic mclk_fall,
  output logic mosi_sync
);

  // Bit 2 select, bit 1 mclk, bit 0 mosi
  logic [2:0] meta_q;
  logic [2:0] sync_q;
  logic       sel_prev;
  logic       mclk_prev;

  always_ff @(posedge sendclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      meta_q    <= '0;
      sync_q    <= '0;
      sel_prev  <= 1'b0;
      mclk_prev <= 1'b0;
    end
    else
    begin
      meta_q    <= {select, mclk, mosi};
      sync_q    <= meta_q;
      sel_prev  <= sync_q[2];
      mclk_prev <= sync_q[1];
    end
  end

  assign sel_level = sync_q[2];
  assign sel_rise  = sync_q[2] & ~sel_prev;
  assign mclk_rise = sync_q[1] & ~mclk_prev;
  assign mclk_fall = ~sync_q[1] & mclk_prev;
  assign mosi_sync = sync_q[0];

  // Edges stay at least four cycles apart as mclk holds each level that long
  a_mclk_edges_apart: assert property (@(posedge sendclk) disable iff (!rst_n)
    (mclk_rise || mclk_fall) |=> !(mclk_rise || mclk_fall)
      ##1 !(mclk_rise || mclk_fall) ##1 !(mclk_rise || mclk_fall));

endmodule

`default_nettype wire

/* spi_proto_pkg.sv */
`default_nettype none

`include "spi_settings.svh"

package spi_proto_pkg;

  typedef logic [`SPI_DATA_W-1:0] spi_data_t;

  // CTRL bit 1 is CPOL, bit 0 is CPHA
  typedef struct packed {
    logic cpol;
    logic cpha;
  } spi_mode_t;

  // STATUS bits 2..0
  typedef struct packed {
    logic overrun;
    logic rx_valid;
    logic busy;
  } spi_status_t;

endpackage

`default_nettype wire

/* spi_regs.sv */
`default_nettype none

`include "spi_settings.svh"

module spi_regs (
  input  logic                    sendclk,
  input  logic                    rst_n,
  input  logic [`AXIL_ADDR_W-1:0] awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [`AXIL_DATA_W-1:0] wdata,
  input  logic                    wvalid,
  output logic                    wready,
  output axil_pkg::axil_resp_t    bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`AXIL_ADDR_W-1:0] araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [`AXIL_DATA_W-1:0] rdata,
  output axil_pkg::axil_resp_t    rresp,
  output logic                    rvalid,
  input  logic                    rready,
  spi_xfer_if.regs                xfer
);
  import spi_proto_pkg::*;
  import axil_pkg::*;

  logic                    wr_accept;
  logic                    rd_accept;
  logic                    wr_bad;
  logic                    rd_bad;
  logic                    rd_clear;
  logic                    ovr_clear;
  reg_idx_t                wr_idx;
  reg_idx_t                rd_idx;
  spi_mode_t               ctrl_q;
  spi_data_t               txdata_q;
  spi_data_t               rxdata_q;
  logic                    rx_valid_q;
  logic                    overrun_q;
  spi_status_t             status;
  logic [`AXIL_DATA_W-1:0] rd_word;

  assign wr_accept = awvalid & wvalid & ~bvalid;
  assign rd_accept = arvalid & ~rvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign arready   = rd_accept;

  assign wr_idx = reg_idx_t'(awaddr[3:2]);
  assign rd_idx = reg_idx_t'(araddr[3:2]);

  // CTRL is locked while a word is on the wire
  assign wr_bad    = (|awaddr[1:0]) | ((wr_idx == IDX_CTRL) & xfer.busy);
  assign rd_bad    = |araddr[1:0];
  assign rd_clear  = rd_accept & ~rd_bad & (rd_idx == IDX_RXDATA);
  assign ovr_clear = wr_accept & ~wr_bad & (wr_idx == IDX_STATUS) & wdata[2];

  assign status = '{overrun: overrun_q, rx_valid: rx_valid_q, busy: xfer.busy};

  assign xfer.mode    = ctrl_q;
  assign xfer.tx_data = txdata_q;

  always_comb
  begin
    rd_word = '0;
    if (!rd_bad)
    begin
      case (rd_idx)
        IDX_CTRL:   rd_word = `AXIL_DATA_W'(ctrl_q);
        IDX_TXDATA: rd_word = `AXIL_DATA_W'(txdata_q);
        IDX_RXDATA: rd_word = `AXIL_DATA_W'(rxdata_q);
        IDX_STATUS: rd_word = `AXIL_DATA_W'(status);
        default:    rd_word = '0;
      endcase
    end
  end

  // Write channel, CTRL and TXDATA
  always_ff @(posedge sendclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bvalid   <= 1'b0;
      bresp    <= RESP_OKAY;
      ctrl_q   <= '0;
      txdata_q <= '0;
    end
    else if (wr_accept)
    begin
      bvalid <= 1'b1;
      bresp  <= wr_bad ? RESP_SLVERR : RESP_OKAY;
      if (!wr_bad && wr_idx == IDX_CTRL)
        ctrl_q <= spi_mode_t'(wdata[$bits(spi_mode_t)-1:0]);
      if (!wr_bad && wr_idx == IDX_TXDATA)
        txdata_q <= spi_data_t'(wdata[`SPI_DATA_W-1:0]);
    end
    else if (bready)
    begin
      bvalid <= 1'b0;
    end
  end

  // Received word and its flags
  always_ff @(posedge sendclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rxdata_q   <= '0;
      rx_valid_q <= 1'b0;
      overrun_q  <= 1'b0;
    end
    else
    begin
      if (xfer.done)
      begin
        rxdata_q   <= xfer.rx_data;
        rx_valid_q <= 1'b1;
      end
      else if (rd_clear)
      begin
        rx_valid_q <= 1'b0;
      end

      // A new word over one nobody has read yet
      if (xfer.done && rx_valid_q && !rd_clear)
        overrun_q <= 1'b1;
      else if (ovr_clear)
        overrun_q <= 1'b0;
    end
  end

  // Read channel
  always_ff @(posedge sendclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rvalid <= 1'b0;
      rresp  <= RESP_OKAY;
    end
    else if (rd_accept)
    begin
      rvalid <= 1'b1;
      rresp  <= rd_bad ? RESP_SLVERR : RESP_OKAY;
    end
    else if (rready)
    begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge sendclk)
  begin
    if (rd_accept)
      rdata <= rd_word;
  end

  a_b_hold: assert property (@(posedge sendclk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

/* spi_settings.svh */
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Bytes per SPI word
`define SPI_NBYTES 1
`define SPI_DATA_W (8 * `SPI_NBYTES)

// AXI4-Lite port widths
`define AXIL_ADDR_W 4
`define AXIL_DATA_W 32

// Register byte offsets
`define REG_CTRL   4'h0
`define REG_TXDATA 4'h4
`define REG_RXDATA 4'h8
`define REG_STATUS 4'hC

`endif

/* spi_slave.sv */
`default_nettype none

`include "spi_settings.svh"

module spi_slave (
  input  logic       sendclk,
  input  logic       rst_n,
  input  logic       sel_level,
  input  logic       sel_rise,
  input  logic       mclk_rise,
  input  logic       mclk_fall,
  input  logic       mosi_sync,
  output logic       miso,
  spi_xfer_if.engine xfer
);
  import spi_proto_pkg::*;

  localparam int W     = `SPI_DATA_W;
  localparam int CNT_W = $clog2(W);

  logic             lead_edge;
  logic             trail_edge;
  logic             sample_edge;
  logic             shift_edge;
  logic             run;
  logic             last_bit;
  logic             active_q;
  logic             done_q;
  logic             miso_q;
  logic [CNT_W-1:0] bit_cnt;
  spi_data_t        tx_sr;
  spi_data_t        rx_sr;

  // Leading edge moves mclk away from its idle level
  assign lead_edge   = xfer.mode.cpol ? mclk_fall : mclk_rise;
  assign trail_edge  = xfer.mode.cpol ? mclk_rise : mclk_fall;
  assign sample_edge = xfer.mode.cpha ? trail_edge : lead_edge;
  assign shift_edge  = xfer.mode.cpha ? lead_edge : trail_edge;

  assign run      = active_q & sel_level;
  assign last_bit = (bit_cnt == CNT_W'(W - 1));

  assign xfer.start   = sel_rise;
  assign xfer.busy    = active_q | sel_rise;
  assign xfer.done    = done_q;
  assign xfer.rx_data = rx_sr;
  assign miso         = miso_q;

  always_ff @(posedge sendclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      miso_q   <= 1'b0;
      bit_cnt  <= '0;
    end
    else
    begin
      done_q <= 1'b0;
      if (!sel_level)
      begin
        // Deselect ends the transfer, before the last sample it is an abort
        active_q <= 1'b0;
        miso_q   <= 1'b0;
      end
      else if (sel_rise)
      begin
        active_q <= 1'b1;
        bit_cnt  <= '0;
        // CPHA 1 waits for the first leading edge to show the MSB
        miso_q   <= xfer.mode.cpha ? 1'b0 : xfer.tx_data[W-1];
      end
      else if (active_q)
      begin
        if (sample_edge)
        begin
          bit_cnt <= bit_cnt + 1'b1;
          if (last_bit)
          begin
            active_q <= 1'b0;
            done_q   <= 1'b1;
            miso_q   <= 1'b0;
          end
        end
        if (shift_edge)
          miso_q <= tx_sr[W-1];
      end
    end
  end

  always_ff @(posedge sendclk)
  begin
    if (sel_rise)
      tx_sr <= xfer.mode.cpha ? xfer.tx_data : (xfer.tx_data << 1);
    else if (run && shift_edge)
      tx_sr <= tx_sr << 1;

    if (run && sample_edge)
      rx_sr <= {rx_sr[W-2:0], mosi_sync};
  end

  a_done_after_busy: assert property (@(posedge sendclk) disable iff (!rst_n)
    xfer.done |-> $past(xfer.busy));

  a_start_done_excl: assert property (@(posedge sendclk) disable iff (!rst_n)
    !(xfer.start && xfer.done));

endmodule

`default_nettype wire

/* spi_subsys_top.sv */
`default_nettype none

`include "spi_settings.svh"

module spi_subsys_top (
  input  logic                    sendclk,
  input  logic                    rst_n,
  input  logic                    select,
  input  logic                    mclk,
  input  logic                    mosi,
  output logic                    miso,
  input  logic [`AXIL_ADDR_W-1:0] awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [`AXIL_DATA_W-1:0] wdata,
  input  logic                    wvalid,
  output logic                    wready,
  output axil_pkg::axil_resp_t    bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`AXIL_ADDR_W-1:0] araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [`AXIL_DATA_W-1:0] rdata,
  output axil_pkg::axil_resp_t    rresp,
  output logic                    rvalid,
  input  logic                    rready
);

  logic sel_level;
  logic sel_rise;
  logic mclk_rise;
  logic mclk_fall;
  logic mosi_sync;

  spi_xfer_if xfer0 ();

  spi_pin_sync pin_sync0 (
    .sendclk   (sendclk),
    .rst_n     (rst_n),
    .select    (select),
    .mclk      (mclk),
    .mosi      (mosi),
    .sel_level (sel_level),
    .sel_rise  (sel_rise),
    .mclk_rise (mclk_rise),
    .mclk_fall (mclk_fall),
    .mosi_sync (mosi_sync)
  );

  spi_slave slave0 (
    .sendclk   (sendclk),
    .rst_n     (rst_n),
    .sel_level (sel_level),
    .sel_rise  (sel_rise),
    .mclk_rise (mclk_rise),
    .mclk_fall (mclk_fall),
    .mosi_sync (mosi_sync),
    .miso      (miso),
    .xfer      (xfer0.engine)
  );

  spi_regs regs0 (
    .sendclk (sendclk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .xfer    (xfer0.regs)
  );

endmodule

`default_nettype wire

/* spi_xfer_if.sv */
`default_nettype none

interface spi_xfer_if;
  import spi_proto_pkg::*;

  spi_mode_t mode;
  spi_data_t tx_data;
  spi_data_t rx_data;
  logic      start;
  logic      done;
  logic      busy;

  modport regs (
    output mode,
    output tx_data,
    input  rx_data,
    input  done,
    input  busy
  );

  // start and done are single-cycle pulses, busy is a level
  modport engine (
    input  mode,
    input  tx_data,
    output rx_data,
    output start,
    output done,
    output busy
  );

endinterface

`default_nettype wire

/* tb_spi_subsys.sv */
`default_nettype none

`include "spi_settings.svh"

module tb_spi_subsys;
  import spi_proto_pkg::*;
  import axil_pkg::*;

  localparam int          W        = `SPI_DATA_W;
  localparam int          HALF     = 6;
  localparam int          HS_LIMIT = 16;
  localparam int          NROWS    = 8;
  localparam int unsigned SEED     = 32'ha1aa_17a7;
  // Four extra slots cover the overrun and busy sections
  localparam longint      WATCHDOG_T = (NROWS + 4) * (W * 12 + 200) * 8;

  typedef struct packed {
    spi_mode_t mode;
    spi_data_t mword;
    spi_data_t sword;
  } xfer_row_t;

  logic                    sendclk;
  logic                    rst_n;
  logic                    select;
  logic                    mclk;
  logic                    mosi;
  logic                    miso;
  logic [`AXIL_ADDR_W-1:0] awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [`AXIL_DATA_W-1:0] wdata;
  logic                    wvalid;
  logic                    wready;
  axil_resp_t              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [`AXIL_ADDR_W-1:0] araddr;
  logic                    arvalid;
  logic                    arready;
  logic [`AXIL_DATA_W-1:0] rdata;
  axil_resp_t              rresp;
  logic                    rvalid;
  logic                    rready;

  xfer_row_t rows [NROWS];

  spi_subsys_top dut0 (
    .sendclk (sendclk),
    .rst_n   (rst_n),
    .select  (select),
    .mclk    (mclk),
    .mosi    (mosi),
    .miso    (miso),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  initial
  begin
    sendclk = 1'b0;
    forever #4 sendclk = ~sendclk;
  end

  initial
  begin
    #(WATCHDOG_T);
    report_problem("Timeout: transfers did not finish");
  end

  task automatic finish_failed();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_problem(input string why);
    $display("%s", why);
    finish_failed();
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("ERR %0t: %s expected %0h actual %0h", $time, name, exp, act);
    finish_failed();
  endtask

  task automatic check_data(input string name, input spi_data_t exp, input spi_data_t act);
    if (act !== exp)
      report_mismatch(name, 64'(exp), 64'(act));
  endtask

  task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
    if (act !== exp)
      report_mismatch(name, 64'(exp), 64'(act));
  endtask

  task automatic check_status(input string name, input spi_status_t exp,
                              input spi_status_t act);
    if (act !== exp)
      report_mismatch(name, 64'(exp), 64'(act));
  endtask

  task automatic check_mode(input string name, input spi_mode_t exp, input spi_mode_t act);
    if (act !== exp)
      report_mismatch(name, 64'(exp), 64'(act));
  endtask

  function automatic spi_status_t make_status(input logic busy, input logic rxv,
                                              input logic ovr);
    spi_status_t s;
    s = '{overrun: ovr, rx_valid: rxv, busy: busy};
    return s;
  endfunction

  function automatic xfer_row_t make_row(input logic cpol, input logic cpha,
                                         input spi_data_t m, input spi_data_t s);
    xfer_row_t row;
    row.mode  = '{cpol: cpol, cpha: cpha};
    row.mword = m;
    row.sword = s;
    return row;
  endfunction

  // Two words per SPI mode
  task automatic load_table();
    rows[0] = make_row(1'b0, 1'b0, 'hA5, 'h3C);
    rows[1] = make_row(1'b0, 1'b0, 'h01, 'h80);
    rows[2] = make_row(1'b0, 1'b1, 'hC3, 'h5A);
    rows[3] = make_row(1'b0, 1'b1, 'hFF, 'h00);
    rows[4] = make_row(1'b1, 1'b0, 'h96, 'h69);
    rows[5] = make_row(1'b1, 1'b0, 'h7E, 'h81);
    rows[6] = make_row(1'b1, 1'b1, 'h12, 'hED);
    rows[7] = make_row(1'b1, 1'b1, 'hF0, 'h0F);
  endtask

  task automatic axi_write(input logic [`AXIL_ADDR_W-1:0] addr,
                           input logic [`AXIL_DATA_W-1:0] data, output axil_resp_t resp);
    int hold;
    int waited;
    hold   = $urandom_range(7, 0);
    waited = 0;
    @(posedge sendclk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    @(negedge sendclk);
    while (!(awready && wready))
    begin
      waited++;
      if (waited > HS_LIMIT)
        report_problem("AXI write was never accepted");
      @(negedge sendclk);
    end
    @(posedge sendclk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge sendclk);
    if (!bvalid)
      report_problem("bvalid did not rise one cycle after the write was accepted");
    resp = bresp;
    // Response must hold while bready stays low
    repeat (hold)
    begin
      @(negedge sendclk);
      if (!bvalid)
        report_problem("bvalid dropped while bready was low");
      check_resp("bresp hold", resp, bresp);
    end
    @(posedge sendclk);
    bready <= 1'b1;
    @(posedge sendclk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [`AXIL_ADDR_W-1:0] addr,
                          output logic [`AXIL_DATA_W-1:0] data, output axil_resp_t resp);
    int hold;
    int waited;
    hold   = $urandom_range(7, 0);
    waited = 0;
    @(posedge sendclk);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge sendclk);
    while (!arready)
    begin
      waited++;
      if (waited > HS_LIMIT)
        report_problem("AXI read was never accepted");
      @(negedge sendclk);
    end
    @(posedge sendclk);
    arvalid <= 1'b0;
    @(negedge sendclk);
    if (!rvalid)
      report_problem("rvalid did not rise one cycle after the read was accepted");
    data = rdata;
    resp = rresp;
    repeat (hold)
    begin
      @(negedge sendclk);
      if (!rvalid)
        report_problem("rvalid dropped while rready was low");
      check_resp("rresp hold", resp, rresp);
      if (rdata !== data)
        report_mismatch("rdata hold", 64'(data), 64'(rdata));
    end
    @(posedge sendclk);
    rready <= 1'b1;
    @(posedge sendclk);
    rready <= 1'b0;
  endtask

  task automatic write_reg(input logic [`AXIL_ADDR_W-1:0] addr,
                           input logic [`AXIL_DATA_W-1:0] data,
                           input axil_resp_t exp_resp, input string name);
    axil_resp_t resp;
    axi_write(addr, data, resp);
    check_resp(name, exp_resp, resp);
  endtask

  task automatic read_reg(input logic [`AXIL_ADDR_W-1:0] addr,
                          output logic [`AXIL_DATA_W-1:0] word, input string name);
    axil_resp_t resp;
    axi_read(addr, word, resp);
    check_resp(name, RESP_OKAY, resp);
  endtask

  // Wait out most of a half period and sample miso away from the edges
  task automatic half_wait();
    repeat (HALF - 1) @(posedge sendclk);
    @(negedge sendclk);
  endtask

  task automatic drop_select();
    @(posedge sendclk);
    select <= 1'b0;
    mosi   <= 1'b0;
    repeat (HALF) @(posedge sendclk);
  endtask

  // SPI master shifting MSB first with mclk toggling every HALF cycles
  task automatic spi_shift(input spi_mode_t mode, input spi_data_t mword, input int nbits,
                           input logic keep_select, output spi_data_t got);
    got = '0;
    @(posedge sendclk);
    mclk <= mode.cpol;
    mosi <= mode.cpha ? 1'b0 : mword[W-1];
    repeat (HALF) @(posedge sendclk);
    select <= 1'b1;
    for (int i = 0; i < nbits; i++)
    begin
      half_wait();
      if (!mode.cpha)
        got = {got[W-2:0], miso};
      @(posedge sendclk);
      if (mode.cpha)
        mosi <= mword[W-1-i];
      mclk <= ~mode.cpol;
      half_wait();
      if (mode.cpha)
        got = {got[W-2:0], miso};
      @(posedge sendclk);
      if (!mode.cpha && i < W - 1)
        mosi <= mword[W-2-i];
      mclk <= mode.cpol;
    end
    if (!keep_select)
    begin
      repeat (HALF) @(posedge sendclk);
      drop_select();
    end
  endtask

  initial
  begin : main_seq
    spi_data_t               got;
    logic [`AXIL_DATA_W-1:0] word;
    spi_mode_t               ovr_mode;
    spi_mode_t               new_mode;
    void'($urandom(SEED));
    rst_n   = 1'b0;
    select  = 1'b0;
    mclk    = 1'b0;
    mosi    = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    load_table();
    repeat (10) @(posedge sendclk);
    rst_n <= 1'b1;
    repeat (2) @(posedge sendclk);

    read_reg(`REG_CTRL, word, "ctrl read resp");
    check_mode("ctrl after reset", '0, spi_mode_t'(word[1:0]));
    read_reg(`REG_TXDATA, word, "txdata read resp");
    check_data("txdata after reset", '0, spi_data_t'(word[W-1:0]));
    read_reg(`REG_RXDATA, word, "rxdata read resp");
    check_data("rxdata after reset", '0, spi_data_t'(word[W-1:0]));
    read_reg(`REG_STATUS, word, "status read resp");
    check_status("status after reset", make_status(1'b0, 1'b0, 1'b0), spi_status_t'(word[2:0]));

    for (int r = 0; r < NROWS; r++)
    begin
      write_reg(`REG_CTRL, `AXIL_DATA_W'(rows[r].mode), RESP_OKAY, "ctrl write resp");
      write_reg(`REG_TXDATA, `AXIL_DATA_W'(rows[r].sword), RESP_OKAY, "txdata write resp");
      read_reg(`REG_CTRL, word, "ctrl read resp");
      check_mode("ctrl readback", rows[r].mode, spi_mode_t'(word[1:0]));
      spi_shift(rows[r].mode, rows[r].mword, W, 1'b0, got);
      check_data("master received", rows[r].sword, got);
      read_reg(`REG_STATUS, word, "status read resp");
      check_status("status after transfer", make_status(1'b0, 1'b1, 1'b0),
                   spi_status_t'(word[2:0]));
      read_reg(`REG_RXDATA, word, "rxdata read resp");
      check_data("rxdata", rows[r].mword, spi_data_t'(word[W-1:0]));
      read_reg(`REG_STATUS, word, "status read resp");
      check_status("status after rxdata read", make_status(1'b0, 1'b0, 1'b0),
                   spi_status_t'(word[2:0]));
    end

    // Second word lands on an unread first word
    ovr_mode = '{cpol: 1'b0, cpha: 1'b1};
    write_reg(`REG_CTRL, `AXIL_DATA_W'(ovr_mode), RESP_OKAY, "ctrl write resp");
    write_reg(`REG_TXDATA, `AXIL_DATA_W'(spi_data_t'('h5A)), RESP_OKAY, "txdata write resp");
    spi_shift(ovr_mode, 'h11, W, 1'b0, got);
    check_data("master received first", 'h5A, got);
    spi_shift(ovr_mode, 'h22, W, 1'b0, got);
    check_data("master received second", 'h5A, got);
    read_reg(`REG_STATUS, word, "status read resp");
    check_status("status with overrun", make_status(1'b0, 1'b1, 1'b1), spi_status_t'(word[2:0]));
    read_reg(`REG_RXDATA, word, "rxdata read resp");
    check_data("rxdata after overrun", 'h22, spi_data_t'(word[W-1:0]));
    read_reg(`REG_STATUS, word, "status read resp");
    check_status("status after read", make_status(1'b0, 1'b0, 1'b1), spi_status_t'(word[2:0]));
    write_reg(`REG_STATUS, 32'h4, RESP_OKAY, "status write resp");
    read_reg(`REG_STATUS, word, "status read resp");
    check_status("overrun cleared", make_status(1'b0, 1'b0, 1'b0), spi_status_t'(word[2:0]));

    // Stop after three bits with select still high
    spi_shift(ovr_mode, 'h33, 3, 1'b1, got);
    read_reg(`REG_STATUS, word, "status read resp");
    check_status("status mid transfer", make_status(1'b1, 1'b0, 1'b0), spi_status_t'(word[2:0]));
    new_mode = '{cpol: 1'b1, cpha: 1'b0};
    write_reg(`REG_CTRL, `AXIL_DATA_W'(new_mode), RESP_SLVERR, "ctrl write while busy");
    read_reg(`REG_CTRL, word, "ctrl read resp");
    check_mode("ctrl kept old mode", ovr_mode, spi_mode_t'(word[1:0]));
    write_reg(4'h6, 32'h77, RESP_SLVERR, "unaligned write");
    read_reg(`REG_TXDATA, word, "txdata read resp");
    check_data("txdata after unaligned write", 'h5A, spi_data_t'(word[W-1:0]));
    drop_select();
    read_reg(`REG_STATUS, word, "status read resp");
    check_status("status after abort", make_status(1'b0, 1'b0, 1'b0), spi_status_t'(word[2:0]));

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
